// ==== Bender.yml ====
package:
  name: row_group

sources:
  - src/row_group_pkg.sv
  - src/line_wr_if.sv
  - src/line_tap_if.sv
  - src/line_rd_if.sv
  - src/line_capture.sv
  - src/row_line_buffer.sv
  - src/row_assembler.sv
  - src/row_group_top.sv
  - target: test
    files:
      - tb/tb_row_group_top.sv

// ==== row_group.f ====
src/row_group_pkg.sv
src/line_wr_if.sv
src/line_tap_if.sv
src/line_rd_if.sv
src/line_capture.sv
src/row_line_buffer.sv
src/row_assembler.sv
src/row_group_top.sv
tb/tb_row_group_top.sv

// ==== src/line_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_capture #(
    parameter int P_ROW_WIDTH  = 256,
    parameter int P_COL_HEIGHT = 256,
    parameter int P_DATA_WIDTH = 8
) (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire [P_DATA_WIDTH-1:0] i_pixel,
    input  wire                    i_h_sync,
    input  wire                    i_v_sync,
    line_wr_if.source              wr,
    line_tap_if.source             tap
);

    localparam int ADDR_W    = $clog2(P_ROW_WIDTH);
    localparam int LINE_W    = $clog2(P_COL_HEIGHT + 1);
    localparam int REMAINDER = P_COL_HEIGHT % row_group_pkg::ROWS_PER_GROUP;

    logic                      valid_in;
    logic                      line_end;
    logic                      final_line;
    logic                      emit_next;
    logic [ADDR_W-1:0]         col_cnt;
    logic [LINE_W-1:0]         line_cnt;
    row_group_pkg::line_slot_e slot;

    assign valid_in   = i_h_sync && i_v_sync;
    assign line_end   = valid_in && (col_cnt == ADDR_W'(P_ROW_WIDTH - 1));
    assign final_line = (line_cnt == LINE_W'(P_COL_HEIGHT - 1));

    // last line of a group, or the last line of a short final group
    assign emit_next = (slot == row_group_pkg::SLOT_LAST) ||
                       ((REMAINDER != 0) && final_line);

    ////////////////////////////////////////////////////////////
    // column, line and slot tracking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            col_cnt  <= '0;
            line_cnt <= '0;
            slot     <= row_group_pkg::SLOT_FIRST;
        end else if (!i_v_sync) begin
            // frame gap restarts the count
            col_cnt  <= '0;
            line_cnt <= '0;
            slot     <= row_group_pkg::SLOT_FIRST;
        end else if (line_end) begin
            col_cnt  <= '0;
            line_cnt <= line_cnt + 1'b1;
            slot     <= row_group_pkg::next_slot(slot);
        end else if (valid_in) begin
            col_cnt  <= col_cnt + 1'b1;
        end else begin
            col_cnt  <= '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // registered tap and write outputs
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tap.valid  <= 1'b0;
            tap.emit   <= 1'b0;
            tap.v_sync <= 1'b0;
            wr.wr_en   <= 1'b0;
        end else begin
            tap.valid  <= valid_in;
            tap.emit   <= valid_in && emit_next;
            tap.v_sync <= i_v_sync;
            // the last line of a group is never stored
            wr.wr_en   <= valid_in && (slot != row_group_pkg::SLOT_LAST);
        end
    end

    always_ff @(posedge i_clk) begin
        tap.pixel  <= i_pixel;
        tap.addr   <= col_cnt;
        tap.slot   <= slot;
        wr.wr_data <= i_pixel;
        wr.wr_addr <= col_cnt;
        wr.slot    <= slot;
    end

endmodule

`default_nettype wire

// ==== src/line_rd_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// stored line reads with data one cycle after rd_en
interface line_rd_if #(
    parameter int P_DATA_WIDTH = 8,
    parameter int P_ADDR_WIDTH = 8
);

    logic                    rd_en;
    logic [P_ADDR_WIDTH-1:0] rd_addr;
    logic [P_DATA_WIDTH-1:0] rd_data0;
    logic [P_DATA_WIDTH-1:0] rd_data1;

    modport initiator (
        output rd_en, rd_addr,
        input  rd_data0, rd_data1
    );

    modport target (
        input  rd_en, rd_addr,
        output rd_data0, rd_data1
    );

endinterface

`default_nettype wire

// ==== src/line_tap_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// registered stream from capture to the assembler
interface line_tap_if #(
    parameter int P_DATA_WIDTH = 8,
    parameter int P_ADDR_WIDTH = 8
);

    logic                      valid;
    logic [P_DATA_WIDTH-1:0]   pixel;
    // column index inside the line
    logic [P_ADDR_WIDTH-1:0]   addr;
    row_group_pkg::line_slot_e slot;
    // pixel must produce an output word
    logic                      emit;
    logic                      v_sync;

    modport source (
        output valid, pixel, addr, slot, emit, v_sync
    );

    modport sink (
        input  valid, pixel, addr, slot, emit, v_sync
    );

endinterface

`default_nettype wire

// ==== src/line_wr_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// line writes from capture into the line memories
interface line_wr_if #(
    parameter int P_DATA_WIDTH = 8,
    parameter int P_ADDR_WIDTH = 8
);

    logic                      wr_en;
    logic [P_ADDR_WIDTH-1:0]   wr_addr;
    logic [P_DATA_WIDTH-1:0]   wr_data;
    // picks the memory
    row_group_pkg::line_slot_e slot;

    modport source (
        output wr_en, wr_addr, wr_data, slot
    );

    modport sink (
        input  wr_en, wr_addr, wr_data, slot
    );

endinterface

`default_nettype wire

// ==== src/row_assembler.sv ====
`timescale 1ns/10ps
`default_nettype none

module row_assembler #(
    parameter int P_COL_HEIGHT = 256,
    parameter int P_DATA_WIDTH = 8
) (
    input  wire                                                    i_clk,
    input  wire                                                    i_rst_n,
    line_tap_if.sink                                               tap,
    line_rd_if.initiator                                           rd,
    output logic [P_DATA_WIDTH*row_group_pkg::ROWS_PER_GROUP-1:0]  o_row,
    output logic                                                   o_h_sync,
    output logic                                                   o_v_sync,
    output logic                                                   o_remainder
);

    localparam int WORD_W    = P_DATA_WIDTH * row_group_pkg::ROWS_PER_GROUP;
    localparam int REMAINDER = P_COL_HEIGHT % row_group_pkg::ROWS_PER_GROUP;
    // free lanes of a short group carry the remainder count
    localparam logic [P_DATA_WIDTH-1:0] PAD = P_DATA_WIDTH'(REMAINDER);

    logic                      emit_d;
    logic                      v_sync_d;
    logic [P_DATA_WIDTH-1:0]   pixel_d;
    row_group_pkg::line_slot_e slot_d;
    logic [WORD_W-1:0]         word;

    // stored lines fetched at the current column
    assign rd.rd_en   = tap.valid && tap.emit;
    assign rd.rd_addr = tap.addr;

    ////////////////////////////////////////////////////////////
    // align the current pixel with the read data
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            emit_d   <= 1'b0;
            v_sync_d <= 1'b0;
        end else begin
            emit_d   <= tap.valid && tap.emit;
            v_sync_d <= tap.v_sync;
        end
    end

    always_ff @(posedge i_clk) begin
        pixel_d <= tap.pixel;
        slot_d  <= tap.slot;
    end

    // top lane holds the oldest line
    always_comb begin
        case (slot_d)
            row_group_pkg::SLOT_LAST:   word = {rd.rd_data0, rd.rd_data1, pixel_d};
            row_group_pkg::SLOT_SECOND: word = {rd.rd_data0, pixel_d, PAD};
            row_group_pkg::SLOT_FIRST:  word = {pixel_d, PAD, PAD};
            default:                    word = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_row       <= '0;
            o_h_sync    <= 1'b0;
            o_v_sync    <= 1'b0;
            o_remainder <= 1'b0;
        end else begin
            o_row       <= emit_d ? word : '0;
            o_h_sync    <= emit_d;
            o_v_sync    <= v_sync_d;
            o_remainder <= emit_d && (slot_d != row_group_pkg::SLOT_LAST);
        end
    end

endmodule

`default_nettype wire

// ==== src/row_group_pkg.sv ====
`default_nettype none

package row_group_pkg;

    ////////////////////////////////////////////////////////////
    // group geometry
    ////////////////////////////////////////////////////////////

    // lines packed into one output word
    localparam int ROWS_PER_GROUP = 3;

    // position of a line inside its group
    typedef enum logic [1:0] {
        SLOT_FIRST  = 2'd0,
        SLOT_SECOND = 2'd1,
        SLOT_LAST   = 2'd2
    } line_slot_e;

    // slot of the next line with wrap after the last one
    function automatic line_slot_e next_slot(input line_slot_e slot);
        case (slot)
            SLOT_FIRST:  return SLOT_SECOND;
            SLOT_SECOND: return SLOT_LAST;
            default:     return SLOT_FIRST;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/row_group_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module row_group_top #(
    parameter int P_ROW_WIDTH  = 256,
    parameter int P_COL_HEIGHT = 256,
    parameter int P_DATA_WIDTH = 8
) (
    input  wire                                                   i_clk,
    input  wire                                                   i_rst_n,
    input  wire  [P_DATA_WIDTH-1:0]                               i_pixel,
    input  wire                                                   i_h_sync,
    input  wire                                                   i_v_sync,
    output wire  [P_DATA_WIDTH*row_group_pkg::ROWS_PER_GROUP-1:0] o_row,
    output wire                                                   o_h_sync,
    output wire                                                   o_v_sync,
    output wire                                                   o_remainder
);

    localparam int ADDR_W = $clog2(P_ROW_WIDTH);

    line_wr_if  #(.P_DATA_WIDTH(P_DATA_WIDTH), .P_ADDR_WIDTH(ADDR_W)) wr_bus  ();
    line_tap_if #(.P_DATA_WIDTH(P_DATA_WIDTH), .P_ADDR_WIDTH(ADDR_W)) tap_bus ();
    line_rd_if  #(.P_DATA_WIDTH(P_DATA_WIDTH), .P_ADDR_WIDTH(ADDR_W)) rd_bus  ();

    ////////////////////////////////////////////////////////////
    // capture, line store, column assembly
    ////////////////////////////////////////////////////////////

    line_capture #(
        .P_ROW_WIDTH  (P_ROW_WIDTH),
        .P_COL_HEIGHT (P_COL_HEIGHT),
        .P_DATA_WIDTH (P_DATA_WIDTH)
    ) u_line_capture (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_pixel  (i_pixel),
        .i_h_sync (i_h_sync),
        .i_v_sync (i_v_sync),
        .wr       (wr_bus),
        .tap      (tap_bus)
    );

    row_line_buffer #(
        .P_ROW_WIDTH  (P_ROW_WIDTH),
        .P_DATA_WIDTH (P_DATA_WIDTH)
    ) u_row_line_buffer (
        .i_clk (i_clk),
        .wr    (wr_bus),
        .rd    (rd_bus)
    );

    row_assembler #(
        .P_COL_HEIGHT (P_COL_HEIGHT),
        .P_DATA_WIDTH (P_DATA_WIDTH)
    ) u_row_assembler (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .tap         (tap_bus),
        .rd          (rd_bus),
        .o_row       (o_row),
        .o_h_sync    (o_h_sync),
        .o_v_sync    (o_v_sync),
        .o_remainder (o_remainder)
    );

endmodule

`default_nettype wire

// ==== src/row_line_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module row_line_buffer #(
    parameter int P_ROW_WIDTH  = 256,
    parameter int P_DATA_WIDTH = 8
) (
    input  wire       i_clk,
    line_wr_if.sink   wr,
    line_rd_if.target rd
);

    localparam int NUM_LINES = row_group_pkg::ROWS_PER_GROUP - 1;

    // read data of each stored line indexed by slot
    wire [NUM_LINES-1:0][P_DATA_WIDTH-1:0] rd_bus;

    ////////////////////////////////////////////////////////////
    // one line memory per stored slot
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_LINES; g++) begin : g_line
        logic [P_DATA_WIDTH-1:0] mem [P_ROW_WIDTH];
        logic [P_DATA_WIDTH-1:0] rd_q;

        always_ff @(posedge i_clk) begin
            if (wr.wr_en && (wr.slot == row_group_pkg::line_slot_e'(g))) begin
                mem[wr.wr_addr] <= wr.wr_data;
            end
        end

        // both lines read at the same column
        always_ff @(posedge i_clk) begin
            if (rd.rd_en) begin
                rd_q <= mem[rd.rd_addr];
            end
        end

        assign rd_bus[g] = rd_q;
    end

    assign rd.rd_data0 = rd_bus[0];
    assign rd.rd_data1 = rd_bus[1];

endmodule

`default_nettype wire

// ==== tb/tb_row_group_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_row_group_top;

    localparam int P_ROW_WIDTH  = 8;
    localparam int P_COL_HEIGHT = 8;
    localparam int P_DATA_WIDTH = 8;

    localparam int GROUP        = row_group_pkg::ROWS_PER_GROUP;
    localparam int WORD_W       = P_DATA_WIDTH * GROUP;
    localparam int REMAINDER    = P_COL_HEIGHT % GROUP;
    localparam int LATENCY      = 3;
    localparam int NUM_FRAMES   = 2;
    localparam int MAX_GAP      = 5;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 20;
    localparam int BLANK_CYCLES = 4;
    // full groups plus one short group
    localparam int WORDS_PER_FRAME = P_ROW_WIDTH * ((P_COL_HEIGHT + GROUP - 1) / GROUP);
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + IDLE_CYCLES + NUM_FRAMES *
        (P_ROW_WIDTH * P_COL_HEIGHT + P_COL_HEIGHT * MAX_GAP + BLANK_CYCLES) + 200;

    typedef struct packed {
        logic              h_sync;
        logic              v_sync;
        logic              remainder;
        logic [WORD_W-1:0] row;
    } out_t;

    logic                    i_clk;
    logic                    i_rst_n;
    logic [P_DATA_WIDTH-1:0] i_pixel;
    logic                    i_h_sync;
    logic                    i_v_sync;
    wire  [WORD_W-1:0]       o_row;
    wire                     o_h_sync;
    wire                     o_v_sync;
    wire                     o_remainder;

    // position of the pixel on the input pins
    int stim_frame;
    int stim_line;
    int stim_col;

    logic [P_DATA_WIDTH-1:0] frame_pix [NUM_FRAMES][P_COL_HEIGHT][P_ROW_WIDTH];
    out_t                    exp_q [$];
    out_t                    exp_now;

    int   checks      = 0;
    int   errors      = 0;
    int   err_mark    = 0;
    int   tests       = 0;
    int   frames_seen = 0;
    int   h_count     = 0;
    int   cycle_cnt   = 0;
    logic v_prev      = 1'b0;

    row_group_top #(
        .P_ROW_WIDTH  (P_ROW_WIDTH),
        .P_COL_HEIGHT (P_COL_HEIGHT),
        .P_DATA_WIDTH (P_DATA_WIDTH)
    ) dut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_pixel     (i_pixel),
        .i_h_sync    (i_h_sync),
        .i_v_sync    (i_v_sync),
        .o_row       (o_row),
        .o_h_sync    (o_h_sync),
        .o_v_sync    (o_v_sync),
        .o_remainder (o_remainder)
    );

    always #2 i_clk = ~i_clk;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // expected outputs for one input cycle
    function automatic out_t expected_out(input logic h_sync, input logic v_sync,
                                          input int f, input int l, input int c);
        out_t                    e;
        int                      base;
        int                      slot;
        logic [P_DATA_WIDTH-1:0] pad;
        e        = '0;
        e.v_sync = v_sync;
        pad      = P_DATA_WIDTH'(REMAINDER);
        if (!(h_sync && v_sync)) begin
            return e;
        end
        base = l - (l % GROUP);
        slot = l % GROUP;
        if (slot == GROUP - 1) begin
            e.h_sync = 1'b1;
            e.row    = {frame_pix[f][base][c], frame_pix[f][base+1][c], frame_pix[f][l][c]};
        end else if ((REMAINDER != 0) && (l == P_COL_HEIGHT - 1)) begin
            // free lanes of the short final group hold the remainder
            e.h_sync    = 1'b1;
            e.remainder = 1'b1;
            if (slot == 0) begin
                e.row = {frame_pix[f][l][c], pad, pad};
            end else begin
                e.row = {frame_pix[f][base][c], frame_pix[f][l][c], pad};
            end
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [WORD_W-1:0] expected,
                               input logic [WORD_W-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // checker sampling on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge i_clk) begin
        if (i_rst_n) begin
            exp_q.push_back(expected_out(i_h_sync, i_v_sync, stim_frame, stim_line, stim_col));
            if (exp_q.size() > LATENCY) begin
                exp_now = exp_q.pop_front();
                check_value("o_h_sync", exp_now.h_sync, o_h_sync);
                check_value("o_v_sync", exp_now.v_sync, o_v_sync);
                check_value("o_remainder", exp_now.remainder, o_remainder);
                check_value("o_row", exp_now.row, o_row);
            end
            if (o_v_sync && o_h_sync) begin
                h_count++;
            end
            // frame closes on the falling output frame sync
            if (v_prev && !o_v_sync) begin
                checks++;
                assert (h_count == WORDS_PER_FRAME) else begin
                    $display("MISMATCH at %0t: o_h_sync words in frame %0d expected %0d got %0d",
                             $time, frames_seen, WORDS_PER_FRAME, h_count);
                    errors++;
                end
                frames_seen++;
                h_count = 0;
            end
            v_prev = o_v_sync;
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic fill_frames();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int l = 0; l < P_COL_HEIGHT; l++) begin
                for (int c = 0; c < P_ROW_WIDTH; c++) begin
                    frame_pix[f][l][c] = P_DATA_WIDTH'($urandom);
                end
            end
        end
    endtask

    task automatic drive_idle(input int cycles, input logic v_sync);
        repeat (cycles) begin
            @(posedge i_clk);
            i_pixel  <= '0;
            i_h_sync <= 1'b0;
            i_v_sync <= v_sync;
        end
    endtask

    // one frame with random gaps between lines
    task automatic drive_frame(input int f);
        int gap;
        for (int l = 0; l < P_COL_HEIGHT; l++) begin
            for (int c = 0; c < P_ROW_WIDTH; c++) begin
                @(posedge i_clk);
                i_pixel    <= frame_pix[f][l][c];
                i_h_sync   <= 1'b1;
                i_v_sync   <= 1'b1;
                stim_frame <= f;
                stim_line  <= l;
                stim_col   <= c;
            end
            if (l < P_COL_HEIGHT - 1) begin
                gap = $urandom % (MAX_GAP + 1);
                drive_idle(gap, 1'b1);
            end
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        void'($urandom(32'h28f));
        i_clk      = 1'b0;
        i_rst_n    = 1'b0;
        i_pixel    = '0;
        i_h_sync   = 1'b0;
        i_v_sync   = 1'b0;
        stim_frame = 0;
        stim_line  = 0;
        stim_col   = 0;
        fill_frames();

        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;

        drive_idle(IDLE_CYCLES, 1'b0);
        report_test("idle after reset");

        drive_frame(0);
        drive_idle(BLANK_CYCLES, 1'b0);
        wait (frames_seen >= 1);
        report_test("frame 0 full and partial groups");

        // second frame right after a short frame sync drop
        drive_frame(1);
        drive_idle(BLANK_CYCLES, 1'b0);
        wait (frames_seen >= 2);
        report_test("frame 1 back to back");

        drive_idle(LATENCY + 1, 1'b0);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
